/* gpio_pkg.sv */
package gpio_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------

   // one configuration word per pin below 0x80 caps the pin count
   localparam int MAX_PINS   = 32;
   localparam int APB_ADDR_W = 8;
   localparam int APB_DATA_W = 32;
   localparam int CFG_W      = 8;
   localparam int INT_TYPE_W = 3;

   typedef logic [MAX_PINS-1:0]   gpio_vec_t;
   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;
   typedef logic [CFG_W-1:0]      cfg_byte_t;

   // ----------------------------------------
   // configuration byte layout
   // ----------------------------------------
   localparam int CFG_OUT_EN_BIT   = 0;
   localparam int CFG_IN_EN_BIT    = 1;
   localparam int CFG_OE_BIT       = 2;
   localparam int CFG_INT_EN_BIT   = 3;
   localparam int CFG_INT_TYPE_LSB = 5;

   // codes 5 to 7 select no source
   typedef enum logic [INT_TYPE_W-1:0] {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_EDGE_POS   = 3'd2,
      INT_EDGE_NEG   = 3'd3,
      INT_EDGE_BOTH  = 3'd4
   } int_type_e;

   // ----------------------------------------
   // register map
   // ----------------------------------------
   localparam apb_addr_t ADDR_CFG_LIMIT = 8'h80;
   localparam apb_addr_t ADDR_INTR      = 8'h80;
   localparam apb_addr_t ADDR_GPIN      = 8'h90;
   localparam apb_addr_t ADDR_GPOUT     = 8'hA0;

   // ones on the implemented pin positions
   function automatic gpio_vec_t pin_mask(input int unsigned num);
      if (num >= MAX_PINS)
      begin
         return '1;
      end
      return (gpio_vec_t'(1) << num) - gpio_vec_t'(1);
   endfunction

endpackage

/* gpio_apb_regs.sv */
`timescale 1ns/1ps

module gpio_apb_regs #(
   parameter int                 GPIO_NUM  = 32,
   parameter gpio_pkg::gpio_vec_t OUT_RESET = '0
) (
   input  logic                   PCLK,
   input  logic                   aresetn,

   // apb slave side
   input  logic                   PSEL_i,
   input  logic                   PENABLE_i,
   input  logic                   PWRITE_i,
   input  gpio_pkg::apb_addr_t    PADDR_i,
   input  gpio_pkg::apb_data_t    PWDATA_i,
   output gpio_pkg::apb_data_t    PRDATA_o,

   // from the interrupt unit
   input  gpio_pkg::gpio_vec_t    gpin_sync_i,
   input  gpio_pkg::gpio_vec_t    intr_reg_i,

   // to the interrupt unit
   output gpio_pkg::gpio_vec_t    int_en_o,
   output gpio_pkg::int_type_e    int_type_o [GPIO_NUM],
   output gpio_pkg::gpio_vec_t    int_clr_o,

   // pins
   output gpio_pkg::gpio_vec_t    GPIO_OUT_o,
   output gpio_pkg::gpio_vec_t    GPIO_OE_o
);

   localparam gpio_pkg::gpio_vec_t PIN_MASK = gpio_pkg::pin_mask(GPIO_NUM);

   gpio_pkg::cfg_byte_t cfg_q [GPIO_NUM];
   gpio_pkg::gpio_vec_t gpout_q;

   logic                wr_en;
   logic                cfg_wr;
   logic                gpout_wr;
   logic                intr_wr;
   logic [5:0]          cfg_idx;

   gpio_pkg::gpio_vec_t out_en;
   gpio_pkg::gpio_vec_t in_en;
   gpio_pkg::gpio_vec_t oe_en;
   gpio_pkg::gpio_vec_t int_en;
   gpio_pkg::apb_data_t cfg_rdata;

   // ----------------------------------------
   // write decode
   // ----------------------------------------

   // zero wait states, so the access phase is the write strobe
   assign wr_en    = PSEL_i & PENABLE_i & PWRITE_i;
   assign cfg_idx  = PADDR_i[7:2];
   assign cfg_wr   = wr_en && (PADDR_i < gpio_pkg::ADDR_CFG_LIMIT);
   assign gpout_wr = wr_en && (PADDR_i == gpio_pkg::ADDR_GPOUT);
   assign intr_wr  = wr_en && (PADDR_i == gpio_pkg::ADDR_INTR);

   // clear mask lives for the write cycle only
   assign int_clr_o = intr_wr ? (PWDATA_i & PIN_MASK) : '0;

   // ----------------------------------------
   // registers
   // ----------------------------------------

   // per-pin configuration bytes
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         for (int i = 0; i < GPIO_NUM; i++)
         begin
            cfg_q[i] <= '0;
         end
      end
      else if (cfg_wr)
      begin
         for (int i = 0; i < GPIO_NUM; i++)
         begin
            if (cfg_idx == 6'(i))
            begin
               cfg_q[i] <= PWDATA_i[gpio_pkg::CFG_W-1:0];
            end
         end
      end
   end

   // output data register, unused pins stay 0
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= OUT_RESET & PIN_MASK;
      end
      else if (gpout_wr)
      begin
         gpout_q <= PWDATA_i & PIN_MASK;
      end
   end

   // ----------------------------------------
   // configuration fields
   // ----------------------------------------
   always_comb
   begin
      out_en = '0;
      in_en  = '0;
      oe_en  = '0;
      int_en = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         out_en[i]     = cfg_q[i][gpio_pkg::CFG_OUT_EN_BIT];
         in_en[i]      = cfg_q[i][gpio_pkg::CFG_IN_EN_BIT];
         oe_en[i]      = cfg_q[i][gpio_pkg::CFG_OE_BIT];
         int_en[i]     = cfg_q[i][gpio_pkg::CFG_INT_EN_BIT];
         int_type_o[i] = gpio_pkg::int_type_e'(
            cfg_q[i][gpio_pkg::CFG_INT_TYPE_LSB +: gpio_pkg::INT_TYPE_W]);
      end
   end

   assign int_en_o = int_en;

   // both pin drivers need the output register enable
   assign GPIO_OUT_o = gpout_q & out_en;
   assign GPIO_OE_o  = oe_en & out_en;

   // ----------------------------------------
   // read mux
   // ----------------------------------------

   // configuration word of the addressed pin, 0 past GPIO_NUM
   always_comb
   begin
      cfg_rdata = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         if (cfg_idx == 6'(i))
         begin
            cfg_rdata = gpio_pkg::apb_data_t'(cfg_q[i]);
         end
      end
   end

   always_comb
   begin
      if (PADDR_i < gpio_pkg::ADDR_CFG_LIMIT)
      begin
         PRDATA_o = cfg_rdata;
      end
      else if (PADDR_i == gpio_pkg::ADDR_INTR)
      begin
         PRDATA_o = intr_reg_i;
      end
      else if (PADDR_i == gpio_pkg::ADDR_GPIN)
      begin
         PRDATA_o = gpin_sync_i & in_en;
      end
      else if (PADDR_i == gpio_pkg::ADDR_GPOUT)
      begin
         PRDATA_o = gpout_q;
      end
      else
      begin
         PRDATA_o = '0;
      end
   end

endmodule

/* gpio_irq_unit.sv */
`timescale 1ns/1ps

module gpio_irq_unit #(
   parameter int GPIO_NUM = 32
) (
   input  logic                   PCLK,
   input  logic                   aresetn,

   input  gpio_pkg::gpio_vec_t    GPIO_IN_i,
   input  gpio_pkg::gpio_vec_t    int_en_i,
   input  gpio_pkg::int_type_e    int_type_i [GPIO_NUM],
   input  gpio_pkg::gpio_vec_t    int_clr_i,

   output gpio_pkg::gpio_vec_t    gpin_sync_o,
   output gpio_pkg::gpio_vec_t    intr_reg_o,
   output gpio_pkg::gpio_vec_t    INT_o,
   output logic                   INT_OR_o
);

   localparam gpio_pkg::gpio_vec_t PIN_MASK = gpio_pkg::pin_mask(GPIO_NUM);

   gpio_pkg::gpio_vec_t gpin1_q;
   gpio_pkg::gpio_vec_t gpin2_q;
   gpio_pkg::gpio_vec_t gpin3_q;

   gpio_pkg::gpio_vec_t rise;
   gpio_pkg::gpio_vec_t fall;
   gpio_pkg::gpio_vec_t toggle;

   gpio_pkg::gpio_vec_t edge_pos_q;
   gpio_pkg::gpio_vec_t edge_neg_q;
   gpio_pkg::gpio_vec_t edge_both_q;

   gpio_pkg::gpio_vec_t int_src;
   gpio_pkg::gpio_vec_t intr_reg_q;

   // ----------------------------------------
   // input synchronizer
   // ----------------------------------------

   // two flops against metastability, third for edge compare
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpin1_q <= '0;
         gpin2_q <= '0;
         gpin3_q <= '0;
      end
      else
      begin
         gpin1_q <= GPIO_IN_i & PIN_MASK;
         gpin2_q <= gpin1_q;
         gpin3_q <= gpin2_q;
      end
   end

   assign gpin_sync_o = gpin3_q;

   // ----------------------------------------
   // edge flags
   // ----------------------------------------
   assign rise   = gpin2_q & ~gpin3_q;
   assign fall   = ~gpin2_q & gpin3_q;
   assign toggle = gpin2_q ^ gpin3_q;

   // sticky until cleared, a new edge beats a clear
   // held at 0 while the pin's interrupt is off
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_q  <= '0;
         edge_neg_q  <= '0;
         edge_both_q <= '0;
      end
      else
      begin
         edge_pos_q  <= int_en_i & (rise | (edge_pos_q & ~int_clr_i));
         edge_neg_q  <= int_en_i & (fall | (edge_neg_q & ~int_clr_i));
         edge_both_q <= int_en_i & (toggle | (edge_both_q & ~int_clr_i));
      end
   end

   // ----------------------------------------
   // source select
   // ----------------------------------------
   always_comb
   begin
      int_src = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         case (int_type_i[i])
            gpio_pkg::INT_LEVEL_HIGH: int_src[i] = gpin3_q[i];
            gpio_pkg::INT_LEVEL_LOW:  int_src[i] = ~gpin3_q[i];
            gpio_pkg::INT_EDGE_POS:   int_src[i] = edge_pos_q[i];
            gpio_pkg::INT_EDGE_NEG:   int_src[i] = edge_neg_q[i];
            gpio_pkg::INT_EDGE_BOTH:  int_src[i] = edge_both_q[i];
            default:                  int_src[i] = 1'b0;
         endcase
      end
   end

   assign INT_o    = int_src & int_en_i;
   assign INT_OR_o = |INT_o;

   // ----------------------------------------
   // interrupt register
   // ----------------------------------------

   // one cycle behind INT_o, a clear write masks it instead
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         intr_reg_q <= '0;
      end
      else if (|int_clr_i)
      begin
         intr_reg_q <= intr_reg_q & ~int_clr_i;
      end
      else
      begin
         intr_reg_q <= INT_o;
      end
   end

   assign intr_reg_o = intr_reg_q;

endmodule

/* gpio_top.sv */
`timescale 1ns/1ps

module gpio_top #(
   parameter int                 GPIO_NUM  = 32,
   parameter gpio_pkg::gpio_vec_t OUT_RESET = '0
) (
   input  logic                   PCLK,
   input  logic                   aresetn,

   // apb slave
   input  logic                   PSEL_i,
   input  logic                   PENABLE_i,
   input  logic                   PWRITE_i,
   input  gpio_pkg::apb_addr_t    PADDR_i,
   input  gpio_pkg::apb_data_t    PWDATA_i,
   output gpio_pkg::apb_data_t    PRDATA_o,
   output logic                   PREADY_o,
   output logic                   PSLVERR_o,

   // pins and interrupts
   input  gpio_pkg::gpio_vec_t    GPIO_IN_i,
   output gpio_pkg::gpio_vec_t    GPIO_OUT_o,
   output gpio_pkg::gpio_vec_t    GPIO_OE_o,
   output gpio_pkg::gpio_vec_t    INT_o,
   output logic                   INT_OR_o
);

   gpio_pkg::gpio_vec_t int_en;
   gpio_pkg::int_type_e int_type [GPIO_NUM];
   gpio_pkg::gpio_vec_t int_clr;
   gpio_pkg::gpio_vec_t gpin_sync;
   gpio_pkg::gpio_vec_t intr_reg;

   // no wait states, no error responses
   assign PREADY_o  = 1'b1;
   assign PSLVERR_o = 1'b0;

   gpio_apb_regs #(
      .GPIO_NUM   (GPIO_NUM),
      .OUT_RESET  (OUT_RESET)
   ) u_regs (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .PSEL_i     (PSEL_i),
      .PENABLE_i  (PENABLE_i),
      .PWRITE_i   (PWRITE_i),
      .PADDR_i    (PADDR_i),
      .PWDATA_i   (PWDATA_i),
      .PRDATA_o   (PRDATA_o),
      .gpin_sync_i(gpin_sync),
      .intr_reg_i (intr_reg),
      .int_en_o   (int_en),
      .int_type_o (int_type),
      .int_clr_o  (int_clr),
      .GPIO_OUT_o (GPIO_OUT_o),
      .GPIO_OE_o  (GPIO_OE_o)
   );

   gpio_irq_unit #(
      .GPIO_NUM   (GPIO_NUM)
   ) u_irq (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .GPIO_IN_i  (GPIO_IN_i),
      .int_en_i   (int_en),
      .int_type_i (int_type),
      .int_clr_i  (int_clr),
      .gpin_sync_o(gpin_sync),
      .intr_reg_o (intr_reg),
      .INT_o      (INT_o),
      .INT_OR_o   (INT_OR_o)
   );

endmodule

/* tb_gpio.sv */
`timescale 1ns/1ps

module tb_gpio;

   localparam int                  GPIO_NUM  = 24;
   localparam gpio_pkg::gpio_vec_t OUT_RESET = 32'h00A5_5A3C;
   localparam gpio_pkg::gpio_vec_t PIN_MASK  = 32'h00FF_FFFF;
   localparam int                  ROUNDS    = 5;
   // five rounds run close to 2000 cycles
   localparam int                  TIMEOUT_CYCLES = 4000;

   logic                PCLK;
   logic                aresetn;
   logic                PSEL_i;
   logic                PENABLE_i;
   logic                PWRITE_i;
   gpio_pkg::apb_addr_t PADDR_i;
   gpio_pkg::apb_data_t PWDATA_i;
   gpio_pkg::apb_data_t PRDATA_o;
   logic                PREADY_o;
   logic                PSLVERR_o;
   gpio_pkg::gpio_vec_t GPIO_IN_i;
   gpio_pkg::gpio_vec_t GPIO_OUT_o;
   gpio_pkg::gpio_vec_t GPIO_OE_o;
   gpio_pkg::gpio_vec_t INT_o;
   logic                INT_OR_o;

   logic [31:0]         lfsr_q;
   int                  err_cnt;
   int                  chk_cnt;
   int                  cycle_cnt = 0;
   gpio_pkg::cfg_byte_t cfg_model [GPIO_NUM];

   gpio_top #(
      .GPIO_NUM  (GPIO_NUM),
      .OUT_RESET (OUT_RESET)
   ) DUT (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .PSEL_i    (PSEL_i),
      .PENABLE_i (PENABLE_i),
      .PWRITE_i  (PWRITE_i),
      .PADDR_i   (PADDR_i),
      .PWDATA_i  (PWDATA_i),
      .PRDATA_o  (PRDATA_o),
      .PREADY_o  (PREADY_o),
      .PSLVERR_o (PSLVERR_o),
      .GPIO_IN_i (GPIO_IN_i),
      .GPIO_OUT_o(GPIO_OUT_o),
      .GPIO_OE_o (GPIO_OE_o),
      .INT_o     (INT_o),
      .INT_OR_o  (INT_OR_o)
   );

   always #2 PCLK = ~PCLK;

   always @(posedge PCLK)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   initial
   begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ----------------------------------------
   // random numbers and compares
   // ----------------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
      return v;
   endfunction

   task automatic check_data(input gpio_pkg::apb_data_t got, input gpio_pkg::apb_data_t exp,
                             input string msg);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("Fail at %0t ns: %s, read %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_vec(input gpio_pkg::gpio_vec_t got, input gpio_pkg::gpio_vec_t exp,
                            input string msg);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("Fail at %0t ns: %s, pins %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("Fail at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      end
   endtask

   // ----------------------------------------
   // bus tasks entered 1 ns after an edge
   // ----------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge PCLK);
      #1;
   endtask

   task automatic apb_write(input gpio_pkg::apb_addr_t addr, input gpio_pkg::apb_data_t data);
      PSEL_i   = 1'b1;
      PWRITE_i = 1'b1;
      PADDR_i  = addr;
      PWDATA_i = data;
      wait_cycles(1);
      PENABLE_i = 1'b1;
      wait_cycles(1);
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
      PWRITE_i  = 1'b0;
   endtask

   task automatic apb_read(input gpio_pkg::apb_addr_t addr, output gpio_pkg::apb_data_t data);
      PSEL_i   = 1'b1;
      PWRITE_i = 1'b0;
      PADDR_i  = addr;
      wait_cycles(1);
      PENABLE_i = 1'b1;
      // mid access phase away from the edge
      #1;
      data = PRDATA_o;
      check_bit(PREADY_o, 1'b1, "PREADY_o in access phase");
      check_bit(PSLVERR_o, 1'b0, "PSLVERR_o in access phase");
      wait_cycles(1);
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
   endtask

   task automatic write_cfg(input int pin, input gpio_pkg::cfg_byte_t b);
      apb_write(gpio_pkg::apb_addr_t'(pin * 4), gpio_pkg::apb_data_t'(b));
      cfg_model[pin] = b;
   endtask

   // one configuration bit gathered over all pins
   function automatic gpio_pkg::gpio_vec_t cfg_field(input int bit_pos);
      gpio_pkg::gpio_vec_t v;
      v = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         v[i] = cfg_model[i][bit_pos];
      end
      return v;
   endfunction

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic test_reset();
      gpio_pkg::apb_data_t rd;
      for (int i = 0; i < 32; i++)
      begin
         apb_read(gpio_pkg::apb_addr_t'(i * 4), rd);
         check_data(rd, '0, $sformatf("config word %0d after reset", i));
      end
      apb_read(gpio_pkg::ADDR_GPOUT, rd);
      check_data(rd, OUT_RESET & PIN_MASK, "GPOUT after reset");
      apb_read(gpio_pkg::ADDR_INTR, rd);
      check_data(rd, '0, "interrupt register after reset");
      check_vec(GPIO_OUT_o, '0, "GPIO_OUT_o after reset");
      check_vec(GPIO_OE_o, '0, "GPIO_OE_o after reset");
      check_vec(INT_o, '0, "INT_o after reset");
      check_bit(INT_OR_o, 1'b0, "INT_OR_o after reset");
   endtask

   task automatic test_config();
      gpio_pkg::apb_data_t rd;
      gpio_pkg::apb_data_t v;
      gpio_pkg::cfg_byte_t b;
      gpio_pkg::gpio_vec_t out_en;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         b = gpio_pkg::cfg_byte_t'(rand_bits(8));
         b[gpio_pkg::CFG_INT_EN_BIT] = 1'b0;
         write_cfg(i, b);
      end
      // words of missing pins take no writes
      for (int i = GPIO_NUM; i < 32; i++)
      begin
         apb_write(gpio_pkg::apb_addr_t'(i * 4), rand_bits(32));
      end
      for (int i = 0; i < 32; i++)
      begin
         apb_read(gpio_pkg::apb_addr_t'(i * 4), rd);
         if (i < GPIO_NUM)
         begin
            check_data(rd, gpio_pkg::apb_data_t'(cfg_model[i]), $sformatf("config word %0d", i));
         end
         else
         begin
            check_data(rd, '0, $sformatf("config word %0d of a missing pin", i));
         end
      end
      v = rand_bits(32);
      apb_write(gpio_pkg::ADDR_GPOUT, v);
      apb_read(gpio_pkg::ADDR_GPOUT, rd);
      check_data(rd, v & PIN_MASK, "GPOUT readback");
      out_en = cfg_field(gpio_pkg::CFG_OUT_EN_BIT);
      check_vec(GPIO_OUT_o, v & PIN_MASK & out_en, "GPIO_OUT_o gating");
      check_vec(GPIO_OE_o, cfg_field(gpio_pkg::CFG_OE_BIT) & out_en, "GPIO_OE_o gating");
   endtask

   task automatic test_input();
      gpio_pkg::apb_data_t rd;
      gpio_pkg::gpio_vec_t v;
      for (int n = 0; n < 8; n++)
      begin
         v = rand_bits(32);
         GPIO_IN_i = v;
         wait_cycles(5);
         apb_read(gpio_pkg::ADDR_GPIN, rd);
         check_data(rd, v & cfg_field(gpio_pkg::CFG_IN_EN_BIT) & PIN_MASK, "GPIN readback");
         check_vec(INT_o, '0, "INT_o with interrupts off");
      end
   endtask

   task automatic test_level();
      gpio_pkg::apb_data_t rd;
      gpio_pkg::cfg_byte_t b;
      gpio_pkg::gpio_vec_t low_mask;
      gpio_pkg::gpio_vec_t v;
      gpio_pkg::gpio_vec_t exp;
      low_mask = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         b = '0;
         b[gpio_pkg::CFG_IN_EN_BIT]  = 1'b1;
         b[gpio_pkg::CFG_INT_EN_BIT] = 1'b1;
         low_mask[i] = rand_bits(1) != 0;
         if (low_mask[i])
         begin
            b[gpio_pkg::CFG_INT_TYPE_LSB +: gpio_pkg::INT_TYPE_W] = gpio_pkg::INT_LEVEL_LOW;
         end
         else
         begin
            b[gpio_pkg::CFG_INT_TYPE_LSB +: gpio_pkg::INT_TYPE_W] = gpio_pkg::INT_LEVEL_HIGH;
         end
         write_cfg(i, b);
      end
      for (int n = 0; n < 4; n++)
      begin
         v = rand_bits(32);
         GPIO_IN_i = v;
         wait_cycles(5);
         exp = (v ^ low_mask) & PIN_MASK;
         check_vec(INT_o, exp, "INT_o for level types");
         check_bit(INT_OR_o, |exp, "INT_OR_o for level types");
         apb_read(gpio_pkg::ADDR_INTR, rd);
         check_data(rd, exp, "interrupt register for level types");
      end
   endtask

   task automatic test_edge();
      gpio_pkg::apb_data_t rd;
      gpio_pkg::cfg_byte_t b;
      gpio_pkg::int_type_e ty [GPIO_NUM];
      gpio_pkg::gpio_vec_t v0;
      gpio_pkg::gpio_vec_t v1;
      gpio_pkg::gpio_vec_t v2;
      gpio_pkg::gpio_vec_t exp;
      gpio_pkg::gpio_vec_t clr;
      int                  r;
      // interrupts off drops any stale edge flags
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         write_cfg(i, '0);
      end
      v0 = rand_bits(32);
      GPIO_IN_i = v0;
      wait_cycles(5);
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         r = int'(rand_bits(2));
         case (r)
            0:       ty[i] = gpio_pkg::INT_EDGE_POS;
            1:       ty[i] = gpio_pkg::INT_EDGE_NEG;
            default: ty[i] = gpio_pkg::INT_EDGE_BOTH;
         endcase
         b = '0;
         b[gpio_pkg::CFG_INT_EN_BIT] = 1'b1;
         b[gpio_pkg::CFG_INT_TYPE_LSB +: gpio_pkg::INT_TYPE_W] = ty[i];
         write_cfg(i, b);
      end
      v1 = rand_bits(32);
      GPIO_IN_i = v1;
      wait_cycles(5);
      v2 = rand_bits(32);
      GPIO_IN_i = v2;
      wait_cycles(5);
      // flags collect both transitions
      exp = '0;
      for (int i = 0; i < GPIO_NUM; i++)
      begin
         case (ty[i])
            gpio_pkg::INT_EDGE_POS: exp[i] = (~v0[i] & v1[i]) | (~v1[i] & v2[i]);
            gpio_pkg::INT_EDGE_NEG: exp[i] = (v0[i] & ~v1[i]) | (v1[i] & ~v2[i]);
            default:                exp[i] = (v0[i] ^ v1[i]) | (v1[i] ^ v2[i]);
         endcase
      end
      check_vec(INT_o, exp, "INT_o for edge types");
      check_bit(INT_OR_o, |exp, "INT_OR_o for edge types");
      apb_read(gpio_pkg::ADDR_INTR, rd);
      check_data(rd, exp, "interrupt register for edge types");
      clr = rand_bits(32);
      apb_write(gpio_pkg::ADDR_INTR, clr);
      wait_cycles(2);
      exp = exp & ~clr;
      check_vec(INT_o, exp, "INT_o after partial clear");
      apb_read(gpio_pkg::ADDR_INTR, rd);
      check_data(rd, exp, "interrupt register after partial clear");
      apb_write(gpio_pkg::ADDR_INTR, '1);
      wait_cycles(2);
      check_vec(INT_o, '0, "INT_o after full clear");
      check_bit(INT_OR_o, 1'b0, "INT_OR_o after full clear");
      apb_read(gpio_pkg::ADDR_INTR, rd);
      check_data(rd, '0, "interrupt register after full clear");
   endtask

   task automatic test_unmapped();
      gpio_pkg::apb_data_t rd;
      gpio_pkg::apb_addr_t addrs [8];
      addrs = '{8'h84, 8'h8C, 8'h94, 8'h9C, 8'hA4, 8'hB0, 8'hC8, 8'hFC};
      for (int i = 0; i < 8; i++)
      begin
         apb_read(addrs[i], rd);
         check_data(rd, '0, $sformatf("unmapped address %h", addrs[i]));
      end
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial
   begin
      PCLK      = 1'b0;
      aresetn   = 1'b0;
      PSEL_i    = 1'b0;
      PENABLE_i = 1'b0;
      PWRITE_i  = 1'b0;
      PADDR_i   = '0;
      PWDATA_i  = '0;
      GPIO_IN_i = '0;
      lfsr_q    = 32'h8041_18cb;
      err_cnt   = 0;
      chk_cnt   = 0;
      wait_cycles(8);
      aresetn = 1'b1;
      wait_cycles(1);
      test_reset();
      for (int r = 0; r < ROUNDS; r++)
      begin
         test_config();
         test_input();
         test_level();
         test_edge();
      end
      test_unmapped();
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
gpio_pkg.sv
gpio_apb_regs.sv
gpio_irq_unit.sv
gpio_top.sv
tb_gpio.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_gpio -Mdir obj_dir
./obj_dir/Vtb_gpio | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   exit 0
else
   exit 1
fi
